// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := tb_csb_req_fifo
FILELIST := vlog.f
OBJDIR   := obj_dir
SIM_BIN  := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
TRACE    := testbench/csb_fifo_trace.txt

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJDIR)

// File: hdl/csb_fifo_pkg.sv
// request fifo sizes and the word, address, count and gray types
package csb_fifo_pkg;

    // ========================================
    // sizes
    // ========================================

    // ram entries
    localparam int FIFO_DEPTH = 4;
    // one configuration bus request word
    localparam int DATA_WIDTH = 50;
    // ram address bits
    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    // count must reach FIFO_DEPTH itself, hence the +1
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    // event counter across the sync chain
    localparam int GRAY_WIDTH = 3;

    // ========================================
    // types
    // ========================================

    // request word as it sits in the ram
    typedef logic [DATA_WIDTH-1:0] data_t;

    // ram address, wraps at depth
    typedef logic [PTR_WIDTH-1:0] ptr_t;

    // occupancy, 0 up to FIFO_DEPTH
    typedef logic [CNT_WIDTH-1:0] count_t;

    // gray event counter
    // only changes are looked at, the value itself means nothing
    typedef logic [GRAY_WIDTH-1:0] gray_t;

endpackage

// File: hdl/csb_req_fifo.sv
// top level of the request fifo: write control, flop ram, event channels, read control
module csb_req_fifo
    import csb_fifo_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic  rd_clk_rd_mgated,
    input  logic  wr_reset_,
    input  logic  wr_req,
    output logic  wr_ready,
    input  data_t wr_data,
    output logic  rd_req,
    input  logic  rd_ready,
    output data_t rd_data
);

    // ========================================
    // internal wires
    // ========================================

    // write side
    logic  wr_pushing;
    logic  wr_popping;
    logic  ram_iwe;
    ptr_t  wr_adr;

    // read side
    logic  rd_pushing;
    logic  rd_popping;
    ptr_t  rd_adr;
    data_t ram_rd_data;

    // accept, hold and reserve ram space
    fifo_wr_ctrl u_wr_ctrl (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .wr_req           (wr_req),
        .wr_ready         (wr_ready),
        .wr_popping       (wr_popping),
        .wr_pushing       (wr_pushing),
        .ram_iwe          (ram_iwe),
        .wr_adr           (wr_adr)
    );

    // data captured on accept, written on push
    fifo_flopram u_ram (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .di               (wr_data),
        .iwe              (ram_iwe),
        .we               (wr_pushing),
        .wa               (wr_adr),
        .ra               (rd_adr),
        .dout             (ram_rd_data)
    );

    // push events toward the read side
    gray_event_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_push_sync (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .event_in         (wr_pushing),
        .event_out        (rd_pushing)
    );

    // pop events back to the write side
    gray_event_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_pop_sync (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .event_in         (rd_popping),
        .event_out        (wr_popping)
    );

    // pop into the output register
    fifo_rd_ctrl u_rd_ctrl (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .rd_pushing       (rd_pushing),
        .rd_popping       (rd_popping),
        .rd_adr           (rd_adr),
        .ram_rd_data      (ram_rd_data),
        .rd_req           (rd_req),
        .rd_ready         (rd_ready),
        .rd_data          (rd_data)
    );

endmodule

// File: hdl/fifo_flopram.sv
// flop ram with internal write data register and combinational read mux
module fifo_flopram
    import csb_fifo_pkg::*;
(
    input  logic  rd_clk_rd_mgated,
    input  data_t di,
    input  logic  iwe,
    input  logic  we,
    input  ptr_t  wa,
    input  ptr_t  ra,
    output data_t dout
);

    // ========================================
    // write data register
    // ========================================

    // word captured at the accepting edge
    data_t di_d;
    // storage, one word per entry
    data_t ram_q [FIFO_DEPTH];

    always_ff @(posedge rd_clk_rd_mgated) begin
        if (iwe) begin
            di_d <= di;
        end
    end

    // ========================================
    // entries
    // ========================================

    // write lands one cycle after capture
    always_ff @(posedge rd_clk_rd_mgated) begin
        if (we) begin
            ram_q[wa] <= di_d;
        end
    end

    // read mux, no clock edge involved
    // the read side only looks here after the push event crossed over
    assign dout = ram_q[ra];

endmodule

// File: hdl/fifo_rd_ctrl.sv
// read control: read count, read address, pop decision, output request and data register
module fifo_rd_ctrl
    import csb_fifo_pkg::*;
(
    input  logic  rd_clk_rd_mgated,
    input  logic  wr_reset_,
    input  logic  rd_pushing,
    output logic  rd_popping,
    output ptr_t  rd_adr,
    input  data_t ram_rd_data,
    output logic  rd_req,
    input  logic  rd_ready,
    output data_t rd_data
);

    // ========================================
    // read-side count
    // ========================================

    // words in the ram as seen from here
    count_t rd_count_p;
    count_t rd_count_p_next;
    // a word can be popped this cycle
    logic   rd_req_p;
    // output register holds a word nobody took yet
    logic   rd_stalled;
    logic   rd_req_next;

    // a push arriving now is already readable
    assign rd_req_p = (rd_count_p != '0) || rd_pushing;

    always_comb begin
        unique case ({rd_pushing, rd_popping})
            2'b10:   rd_count_p_next = count_t'(rd_count_p + 1'b1);
            2'b01:   rd_count_p_next = count_t'(rd_count_p - 1'b1);
            default: rd_count_p_next = rd_count_p;
        endcase
    end

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            rd_count_p <= '0;
        end else begin
            rd_count_p <= rd_count_p_next;
        end
    end

    // ========================================
    // pop and read address
    // ========================================

    assign rd_stalled = rd_req && !rd_ready;

    // pop when output register is free or being taken
    assign rd_popping = rd_req_p && !rd_stalled;

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            rd_adr <= '0;
        end else if (rd_popping) begin
            rd_adr <= ptr_t'(rd_adr + 1'b1);
        end
    end

    // ========================================
    // output register
    // ========================================

    // keep request up while the word waits
    assign rd_req_next = rd_req_p || rd_stalled;

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            rd_req <= 1'b0;
        end else begin
            rd_req <= rd_req_next;
        end
    end

    // payload only, stable while stalled
    always_ff @(posedge rd_clk_rd_mgated) begin
        if (rd_popping) begin
            rd_data <= ram_rd_data;
        end
    end

endmodule

// File: hdl/fifo_wr_ctrl.sv
// write control: input holding register, write count, busy and ready, write address
module fifo_wr_ctrl
    import csb_fifo_pkg::*;
(
    input  logic rd_clk_rd_mgated,
    input  logic wr_reset_,
    input  logic wr_req,
    output logic wr_ready,
    input  logic wr_popping,
    output logic wr_pushing,
    output logic ram_iwe,
    output ptr_t wr_adr
);

    // ========================================
    // input holding register
    // ========================================

    // registered request, valid the cycle after accept
    logic   wr_req_in;
    // ready flag source, inputs held this cycle
    logic   wr_busy_in;
    // internal copy of busy, used for reserving
    logic   wr_busy_int;
    logic   wr_busy_next;
    logic   wr_busy_in_next;
    // held word cannot reserve yet
    logic   wr_busy_in_int;
    logic   wr_reserving;
    count_t wr_count;
    count_t wr_count_next;

    assign wr_ready = !wr_busy_in;

    // data goes into the ram write register on accept
    assign ram_iwe = wr_req && !wr_busy_in;

    // stay busy with a new request if the fifo fills next cycle
    // without one, only a held word that still cannot reserve keeps us busy
    assign wr_busy_in_next = wr_req ? wr_busy_next
                                    : (wr_req_in && wr_busy_next && !wr_reserving);

    assign wr_busy_in_int = wr_req_in && wr_busy_int;

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            wr_req_in  <= 1'b0;
            wr_busy_in <= 1'b0;
        end else begin
            wr_busy_in <= wr_busy_in_next;
            // keep the held request until space shows up
            if (!wr_busy_in_int) begin
                wr_req_in <= wr_req && !wr_busy_in;
            end
        end
    end

    // ========================================
    // write-side count
    // ========================================

    // reserve a ram slot for the registered request
    assign wr_reserving = wr_req_in && !wr_busy_int;
    // push in the same cycle as the reservation
    assign wr_pushing = wr_reserving;

    // up on push, down on returned pop, both cancel
    always_comb begin
        unique case ({wr_reserving, wr_popping})
            2'b10:   wr_count_next = count_t'(wr_count + 1'b1);
            2'b01:   wr_count_next = count_t'(wr_count - 1'b1);
            default: wr_count_next = wr_count;
        endcase
    end

    // busy next cycle when the ram is fully reserved
    assign wr_busy_next = (wr_count_next == count_t'(FIFO_DEPTH));

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            wr_busy_int <= 1'b0;
            wr_count    <= '0;
        end else begin
            wr_busy_int <= wr_busy_next;
            wr_count    <= wr_count_next;
        end
    end

    // ========================================
    // write address
    // ========================================

    // wraps naturally at depth 4
    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            wr_adr <= '0;
        end else if (wr_pushing) begin
            wr_adr <= ptr_t'(wr_adr + 1'b1);
        end
    end

endmodule

// File: hdl/gray_event_sync.sv
// gray event channel: sender counter, synchronizer chain, receiver that regenerates pulses
module gray_event_sync
    import csb_fifo_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic rd_clk_rd_mgated,
    input  logic wr_reset_,
    input  logic event_in,
    output logic event_out
);

    // ========================================
    // gray step
    // ========================================

    // polarity 0 flips the lsb
    // otherwise flip the bit left of the rightmost one, msb if that one is at bit 1
    function automatic gray_t gray_next(input gray_t g);
        logic polarity;
        polarity = ^g;
        return {g[2] ^ (polarity & ~g[0]),
                g[1] ^ (polarity & g[0]),
                g[0] ^ ~polarity};
    endfunction

    // sender copy, moves one step per event
    gray_t snd_gray;
    // chain stages, index 0 sees the sender first
    gray_t sync_q [SYNC_STAGES];
    // receiver copy, trails the chain output
    gray_t rcv_gray;

    // ========================================
    // sender
    // ========================================

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            snd_gray <= '0;
        end else if (event_in) begin
            snd_gray <= gray_next(snd_gray);
        end
    end

    // ========================================
    // synchronizer chain
    // ========================================

    // one bit changes per step, so each stage carries a clean value
    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= snd_gray;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // ========================================
    // receiver
    // ========================================

    // pulse while behind the chain output
    // back-to-back events arrive one step per cycle and stay separate
    assign event_out = (sync_q[SYNC_STAGES-1] != rcv_gray);

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            rcv_gray <= '0;
        end else if (event_out) begin
            rcv_gray <= gray_next(rcv_gray);
        end
    end

endmodule

// File: testbench/csb_fifo_trace.txt
# columns: request word (50-bit hex), idle cycles before the write,
# cycles the reader holds rd_ready low before taking the word
2a51c0f3e8d17 0 0
0000000000000 0 0
3ffffffffffff 0 1
2aaaaaaaaaaaa 1 0
1555555555555 0 3
0123456789abc 2 0
3edcba9876543 0 0
1f0e1d2c3b4a5 0 4
00000000000ff 3 2
3000000000001 0 0
2468ace02468a 1 1
13579bdf13579 0 0
0f0f0f0f0f0f0 0 2
30f0f0f0f0f0f 2 0
1c3a5e7092b4d 0 0
2d4b6f8091a3c 0 4
0badcafe12345 3 0
3c0ffee0beef1 0 1
1234567890123 1 3
2fedcba012345 0 0

// File: testbench/tb_csb_req_fifo.sv
// testbench for the request fifo: trace stimulus, scoreboard, compare tasks, lfsr, watchdog
module tb_csb_req_fifo
    import csb_fifo_pkg::*;
;
    localparam int    SYNC_STAGES = 2;
    localparam int    LATENCY     = 2 + SYNC_STAGES;
    localparam string TRACE_FILE  = "testbench/csb_fifo_trace.txt";

    logic  rd_clk_rd_mgated;
    logic  wr_reset_;
    logic  wr_req;
    logic  wr_ready;
    data_t wr_data;
    logic  rd_req;
    logic  rd_ready;
    data_t rd_data;

    // trace columns, one entry per request
    data_t       trace_word[$];
    int          trace_gap[$];
    int          trace_stall[$];
    // words still owed by the dut
    data_t       exp_q[$];
    int          max_gap;
    int          max_stall;
    int          limit_cycles;
    logic        trace_loaded = 1'b0;
    logic [31:0] lfsr_state   = 32'h62352894;

    csb_req_fifo #(.SYNC_STAGES(SYNC_STAGES)) i_dut (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .wr_req           (wr_req),
        .wr_ready         (wr_ready),
        .wr_data          (wr_data),
        .rd_req           (rd_req),
        .rd_ready         (rd_ready),
        .rd_data          (rd_data)
    );

    initial begin
        rd_clk_rd_mgated = 1'b0;
        forever #2 rd_clk_rd_mgated = ~rd_clk_rd_mgated;
    end

    // ========================================
    // compare tasks and lfsr
    // ========================================

    task automatic compare_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic compare_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            $display("Verification failed");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            $display("Verification failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // taps 32 22 2 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // ========================================
    // trace loading and watchdog
    // ========================================

    task automatic load_trace();
        int    fd;
        int    n;
        int    gap;
        int    stall;
        data_t word;
        string line;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            $display("Verification failed");
            $fatal(1, "no trace");
        end
        max_gap   = 0;
        max_stall = 0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // skip comment lines and blank lines
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %d %d", word, gap, stall);
                if (n == 3) begin
                    trace_word.push_back(word);
                    trace_gap.push_back(gap);
                    trace_stall.push_back(stall);
                    max_gap   = (gap > max_gap) ? gap : max_gap;
                    max_stall = (stall > max_stall) ? stall : max_stall;
                end
            end
        end
        $fclose(fd);
        if (trace_word.size() == 0) begin
            $display("the trace file holds no requests");
            $display("Verification failed");
            $fatal(1, "empty trace");
        end
        limit_cycles = trace_word.size() * (max_gap + max_stall + LATENCY + 8) + 100;
        trace_loaded = 1'b1;
    endtask

    initial begin
        wait (trace_loaded);
        repeat (limit_cycles) @(posedge rd_clk_rd_mgated);
        $display("watchdog: the run hung and did not end within %0d cycles", limit_cycles);
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    // ========================================
    // stimulus tasks, entered on a falling edge
    // ========================================

    // offer one word until the fifo takes it
    task automatic write_word(input data_t w);
        logic acc;
        wr_req  = 1'b1;
        wr_data = w;
        do begin
            acc = wr_ready;
            @(negedge rd_clk_rd_mgated);
        end while (!acc);
        wr_req = 1'b0;
    endtask

    // empty fifo, reader always ready
    // returns one falling edge after the accepting edge
    task automatic single_word();
        wr_data  = trace_word[0];
        rd_ready = 1'b1;
        write_word(trace_word[0]);
        for (int k = 1; k <= LATENCY; k++) begin
            compare_flag("single word latency", 1'b0, rd_req);
            @(negedge rd_clk_rd_mgated);
        end
        compare_flag("single word latency", 1'b1, rd_req);
        compare_data("single word data", trace_word[0], rd_data);
        @(negedge rd_clk_rd_mgated);
        compare_flag("single word drained", 1'b0, rd_req);
    endtask

    task automatic write_trace();
        for (int i = 0; i < trace_word.size(); i++) begin
            repeat (trace_gap[i]) @(negedge rd_clk_rd_mgated);
            write_word(trace_word[i]);
        end
    endtask

    // stall each word, then take it; lfsr adds an odd extra cycle
    task automatic read_trace();
        data_t held;
        int    stall;
        for (int i = 0; i < trace_word.size(); i++) begin
            rd_ready = 1'b0;
            while (!rd_req) @(negedge rd_clk_rd_mgated);
            held  = rd_data;
            stall = trace_stall[i] + int'(next_lfsr_bit());
            repeat (stall) begin
                @(negedge rd_clk_rd_mgated);
                compare_flag("stall holds rd_req", 1'b1, rd_req);
                compare_data("stall holds rd_data", held, rd_data);
            end
            rd_ready = 1'b1;
            compare_data("trace order", exp_q.pop_front(), rd_data);
            @(negedge rd_clk_rd_mgated);
        end
        rd_ready = 1'b0;
    endtask

    // writes every cycle against a blocked reader, then drain
    task automatic fill_and_drain();
        int    accepted;
        data_t fill_q[$];
        accepted = 0;
        rd_ready = 1'b0;
        wr_req   = 1'b1;
        wr_data  = trace_word[0];
        repeat (16) begin
            if (wr_ready) begin
                fill_q.push_back(wr_data);
                accepted++;
            end
            @(negedge rd_clk_rd_mgated);
            wr_data = trace_word[accepted % trace_word.size()];
        end
        wr_req = 1'b0;
        compare_count("fill limit", count_t'(FIFO_DEPTH + 2),
                      count_t'((accepted > 7) ? 7 : accepted));
        compare_flag("wr_ready low when full", 1'b0, wr_ready);
        rd_ready = 1'b1;
        while (fill_q.size() > 0) begin
            while (!rd_req) @(negedge rd_clk_rd_mgated);
            compare_data("drain order", fill_q.pop_front(), rd_data);
            @(negedge rd_clk_rd_mgated);
        end
        repeat (LATENCY + 2) @(negedge rd_clk_rd_mgated);
        compare_flag("wr_ready back after drain", 1'b1, wr_ready);
        compare_flag("rd_req low after drain", 1'b0, rd_req);
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        wr_reset_ = 1'b0;
        wr_req    = 1'b0;
        wr_data   = '0;
        rd_ready  = 1'b0;
        load_trace();
        repeat (8) @(negedge rd_clk_rd_mgated);
        wr_reset_ = 1'b1;
        @(negedge rd_clk_rd_mgated);
        compare_flag("reset wr_ready", 1'b1, wr_ready);
        compare_flag("reset rd_req", 1'b0, rd_req);
        single_word();
        exp_q = trace_word;
        fork
            write_trace();
            read_trace();
        join
        // let the last pop events settle on the write side
        repeat (LATENCY + 2) @(negedge rd_clk_rd_mgated);
        compare_flag("trace drained rd_req", 1'b0, rd_req);
        compare_flag("trace drained wr_ready", 1'b1, wr_ready);
        fill_and_drain();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: vlog.f
hdl/csb_fifo_pkg.sv
hdl/gray_event_sync.sv
hdl/fifo_flopram.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/csb_req_fifo.sv
testbench/tb_csb_req_fifo.sv
